// ==== common/lsu_pkg.sv ====
package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int LSU_XLEN   = 32;            // isa word, data and address
  localparam int LSU_NBYTES = LSU_XLEN / 8;  // byte lanes per word
  localparam int LSU_OFF_W  = 2;             // in-word byte offset

  // access size, same coding as the ex stage data type
  typedef enum logic [1:0]
  {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  // controller states
  typedef enum logic [1:0]
  {
    ST_IDLE        = 2'b00,  // nothing outstanding
    ST_WAIT_RVALID = 2'b01,  // granted, data not back yet
    ST_WAIT_RSP    = 2'b10   // data held until write-back takes it
  } lsu_state_e;

  ////////////////////
  // bundles
  ////////////////////

  // request from the ex stage
  typedef struct packed
  {
    logic                 we;          // store when set
    lsu_size_e            size;
    logic                 sign_ext;    // sign extend loaded data
    logic [LSU_XLEN-1:0]  op_a;        // base address
    logic [LSU_XLEN-1:0]  op_b;        // address increment
    logic                 use_incr;    // address is a + b
    logic [LSU_XLEN-1:0]  wdata;       // store data as held in the register
    logic [LSU_OFF_W-1:0] reg_offset;  // byte offset of the data inside the register
  } lsu_req_t;

  // command on the data memory port
  typedef struct packed
  {
    logic [LSU_XLEN-1:0]   addr;
    logic                  we;
    logic [LSU_NBYTES-1:0] be;
    logic [LSU_XLEN-1:0]   wdata;
  } mem_cmd_t;

  // response to write-back
  typedef struct packed
  {
    logic [LSU_XLEN-1:0] rdata;  // aligned and extended load data
    logic                err;    // bus error seen at grant
    logic                we;     // marks a store's response
  } lsu_rsp_t;

endpackage

// ==== lsu/lsu_ctrl.sv ====
module lsu_ctrl
(
  input  logic clk,
  input  logic rst_n,

  // pipeline request
  input  logic req_valid_i,
  output logic req_ready_o,

  // memory side
  output logic mem_req_o,
  input  logic mem_gnt_i,
  input  logic mem_rvalid_i,

  // write-back response
  output logic rsp_valid_o,
  input  logic rsp_ready_i,

  // load path control
  output logic capture_o,   // register attributes of the granted access
  output logic hold_o,      // register the result, write-back stalled

  output logic busy_o
);

  import lsu_pkg::*;

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       can_issue;   // a new request may go out this cycle

  ////////////////////
  // outputs
  ////////////////////

  always_comb
  begin
    can_issue   = 1'b0;
    rsp_valid_o = 1'b0;
    hold_o      = 1'b0;

    case (state_q)
      ST_IDLE:
      begin
        can_issue = 1'b1;
      end

      ST_WAIT_RVALID:
      begin
        if (mem_rvalid_i)
        begin
          rsp_valid_o = 1'b1;            // data straight from memory
          if (rsp_ready_i)
            can_issue = 1'b1;            // overlap next access with this response
          else
            hold_o    = 1'b1;            // keep it for later
        end
      end

      ST_WAIT_RSP:
      begin
        rsp_valid_o = 1'b1;              // from the hold register
      end

      default:
      begin
        can_issue = 1'b0;
      end
    endcase
  end

  assign mem_req_o   = can_issue & req_valid_i;
  assign req_ready_o = can_issue & mem_gnt_i;   // accept exactly on grant
  assign capture_o   = mem_req_o & mem_gnt_i;
  assign busy_o      = (state_q != ST_IDLE) | mem_req_o;

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_d = state_q;

    case (state_q)
      ST_IDLE:
      begin
        if (capture_o)
          state_d = ST_WAIT_RVALID;
      end

      ST_WAIT_RVALID:
      begin
        if (mem_rvalid_i)
        begin
          if (!rsp_ready_i)
            state_d = ST_WAIT_RSP;       // back-pressure, stop issuing
          else if (capture_o)
            state_d = ST_WAIT_RVALID;    // next access already granted
          else
            state_d = ST_IDLE;
        end
      end

      ST_WAIT_RSP:
      begin
        if (rsp_ready_i)
          state_d = ST_IDLE;
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

endmodule

// ==== lsu/lsu_load_align.sv ====
module lsu_load_align
(
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          capture_i,   // grant accepted this cycle
  input  logic                          hold_i,      // rvalid but response not taken

  // attributes of the access being granted
  input  lsu_pkg::lsu_size_e            size_i,
  input  logic                          sign_ext_i,
  input  logic                          we_i,
  input  logic [lsu_pkg::LSU_OFF_W-1:0] offset_i,
  input  logic                          err_i,       // bus error at grant

  input  logic [lsu_pkg::LSU_XLEN-1:0]  rdata_i,     // word from memory
  input  logic                          rvalid_i,
  output lsu_pkg::lsu_rsp_t             rsp_o        // to write-back
);

  import lsu_pkg::*;

  // attributes of the access in flight
  lsu_size_e            size_q;
  logic                 sign_ext_q;
  logic                 we_q;
  logic [LSU_OFF_W-1:0] offset_q;
  logic                 err_q;

  logic [LSU_XLEN-1:0]  rdata_sh;    // addressed byte moved down to lane 0
  logic [LSU_XLEN-1:0]  rdata_ext;   // extracted and extended
  lsu_rsp_t             rsp_live;    // result in the rvalid cycle
  lsu_rsp_t             rsp_q;       // result held for a stalled write-back

  // latch attributes on the grant edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      offset_q   <= '0;
      err_q      <= 1'b0;
    end
    else if (capture_i)
    begin
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
      offset_q   <= offset_i;
      err_q      <= err_i;
    end
  end

  ////////////////////
  // extraction
  ////////////////////

  // zero fill from the top, bytes past the word end read as zero
  assign rdata_sh = rdata_i >> {offset_q, 3'b000};

  always_comb
  begin
    case (size_q)
      SIZE_WORD: rdata_ext = rdata_sh;  // no extension needed
      SIZE_HALF: rdata_ext = {{(LSU_XLEN-16){sign_ext_q & rdata_sh[15]}}, rdata_sh[15:0]};
      default:   rdata_ext = {{(LSU_XLEN-8){sign_ext_q & rdata_sh[7]}}, rdata_sh[7:0]};
    endcase
  end

  assign rsp_live = '{rdata: rdata_ext, err: err_q, we: we_q};

  // hold register, loaded only when write-back is not ready
  always_ff @(posedge clk)
  begin
    if (hold_i)
      rsp_q <= rsp_live;
  end

  assign rsp_o = rvalid_i ? rsp_live : rsp_q;  // live data wins in the rvalid cycle

endmodule

// ==== lsu/lsu_store_align.sv ====
module lsu_store_align
(
  input  lsu_pkg::lsu_req_t req_i,         // request from the ex stage
  output lsu_pkg::mem_cmd_t mem_cmd_o,     // command towards data memory
  output logic              misaligned_o   // access runs past the word end
);

  import lsu_pkg::*;

  logic [LSU_XLEN-1:0]   addr;       // byte address of the access
  logic [LSU_OFF_W-1:0]  addr_off;   // byte offset inside the word
  logic [LSU_OFF_W-1:0]  rot_off;    // lane rotation of the store data
  logic [LSU_NBYTES-1:0] be_base;    // enables as if the offset were zero
  logic [LSU_NBYTES-1:0] be;         // enables at the real offset
  logic [2*LSU_XLEN-1:0] wdata_dbl;  // doubled word, shifted for the rotate

  ////////////////////
  // address
  ////////////////////

  assign addr     = req_i.use_incr ? (req_i.op_a + req_i.op_b) : req_i.op_a;
  assign addr_off = addr[LSU_OFF_W-1:0];

  // word off a boundary, or half-word in the last lane
  always_comb
  begin
    case (req_i.size)
      SIZE_WORD: misaligned_o = (addr_off != '0);
      SIZE_HALF: misaligned_o = (addr_off == '1);
      default:   misaligned_o = 1'b0;  // a byte always fits
    endcase
  end

  ////////////////////
  // byte enables
  ////////////////////

  always_comb
  begin
    case (req_i.size)
      SIZE_WORD: be_base = '1;
      SIZE_HALF: be_base = LSU_NBYTES'(2'b11);
      default:   be_base = LSU_NBYTES'(1'b1);
    endcase
  end

  // lanes shifted past the top fall off, so only the in-word part is enabled
  assign be = be_base << addr_off;

  ////////////////////
  // store data
  ////////////////////

  // data sits at reg_offset in the register, must land at addr_off in memory
  assign rot_off = addr_off - req_i.reg_offset;  // wraps around the word

  // upper half of the shifted double word is the rotate left
  assign wdata_dbl = {req_i.wdata, req_i.wdata} << {rot_off, 3'b000};

  assign mem_cmd_o = '{
    addr:  addr,
    we:    req_i.we,                               // passed on as is
    be:    be,
    wdata: wdata_dbl[2*LSU_XLEN-1 -: LSU_XLEN]
  };

endmodule

// ==== lsu/lsu_top.sv ====
module lsu_top
(
  input  logic                         clk,
  input  logic                         rst_n,

  // ex stage request
  input  lsu_pkg::lsu_req_t            req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  output logic                         misaligned_o,

  // data memory
  output logic                         mem_req_o,
  output lsu_pkg::mem_cmd_t            mem_cmd_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic                         mem_err_i,     // valid with the grant only
  input  logic [lsu_pkg::LSU_XLEN-1:0] mem_rdata_i,

  // write-back response
  output lsu_pkg::lsu_rsp_t            rsp_o,
  output logic                         rsp_valid_o,
  input  logic                         rsp_ready_i,

  output logic                         busy_o
);

  import lsu_pkg::*;

  logic capture;   // grant accepted
  logic hold;      // response stalled

  // address, enables and store lanes
  lsu_store_align u_store
  (
    .req_i        ( req_i        ),
    .mem_cmd_o    ( mem_cmd_o    ),
    .misaligned_o ( misaligned_o )
  );

  // load data path and response register
  lsu_load_align u_load
  (
    .clk        ( clk                                ),
    .rst_n      ( rst_n                              ),
    .capture_i  ( capture                            ),
    .hold_i     ( hold                               ),
    .size_i     ( req_i.size                         ),
    .sign_ext_i ( req_i.sign_ext                     ),
    .we_i       ( req_i.we                           ),
    .offset_i   ( mem_cmd_o.addr[LSU_OFF_W-1:0]      ),   // low address bits
    .err_i      ( mem_err_i                          ),
    .rdata_i    ( mem_rdata_i                        ),
    .rvalid_i   ( mem_rvalid_i                       ),
    .rsp_o      ( rsp_o                              )
  );

  // handshake sequencing
  lsu_ctrl u_ctrl
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .mem_req_o    ( mem_req_o    ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .capture_o    ( capture      ),
    .hold_o       ( hold         ),
    .busy_o       ( busy_o       )
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lsu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module lsu_tb \
     -f src.f --Mdir obj_dir -o lsu_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/lsu_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi

exit 0

// ==== src.f ====
common/lsu_pkg.sv
lsu/lsu_store_align.sv
lsu/lsu_load_align.sv
lsu/lsu_ctrl.sv
lsu/lsu_top.sv
testbench/lsu_mem_model.sv
testbench/lsu_tb.sv

// ==== testbench/lsu_mem_model.sv ====
module lsu_mem_model
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         mem_req_i,
  input  lsu_pkg::mem_cmd_t            mem_cmd_i,
  input  logic                         err_inject_i,  // raise a bus error on this grant
  output logic                         mem_gnt_o,
  output logic                         mem_rvalid_o,
  output logic                         mem_err_o,
  output logic [lsu_pkg::LSU_XLEN-1:0] mem_rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int DEPTH = 16;

  logic [LSU_XLEN-1:0] mem [DEPTH];
  integer              seed = 32'h19ca2848;
  logic [1:0]          gnt_wait;   // cycles left before the next grant
  logic [1:0]          rv_wait;    // cycles left before rvalid
  logic                pend;       // one access granted, no rvalid yet
  logic [LSU_XLEN-1:0] rdata_q;    // word read at grant
  logic [3:0]          widx;

  // 0..2 from the seeded generator
  function automatic logic [1:0] pick_delay();
    logic [31:0] rnd;
    rnd = $random(seed);
    return 2'(rnd % 32'd3);
  endfunction

  assign widx         = mem_cmd_i.addr[5:2];              // 16 words, upper bits ignored
  assign mem_rvalid_o = pend && (rv_wait == 2'd0);
  assign mem_gnt_o    = mem_req_i && (gnt_wait == 2'd0) && (!pend || mem_rvalid_o);
  assign mem_err_o    = mem_gnt_o && err_inject_i;
  assign mem_rdata_o  = mem_rvalid_o ? rdata_q : '0;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // every byte lane gets its own address, odd lanes inverted so bit 7 is set
      for (int w = 0; w < DEPTH; w++)
        mem[w] <= {~8'(4*w+3), 8'(4*w+2), ~8'(4*w+1), 8'(4*w)};
      gnt_wait <= 2'd0;
      rv_wait  <= 2'd0;
      pend     <= 1'b0;
      rdata_q  <= '0;
    end
    else if (mem_gnt_o)
    begin
      gnt_wait <= pick_delay();
      rv_wait  <= pick_delay();   // rvalid 1..3 cycles after the grant
      pend     <= 1'b1;
      if (mem_cmd_i.we)
      begin
        rdata_q <= '0;            // stores answer with zero
        if (!err_inject_i)
        begin
          for (int b = 0; b < LSU_NBYTES; b++)
            if (mem_cmd_i.be[b])
              mem[widx][8*b +: 8] <= mem_cmd_i.wdata[8*b +: 8];
        end
      end
      else
        rdata_q <= mem[widx];
    end
    else
    begin
      if (mem_req_i && (gnt_wait != 2'd0))
        gnt_wait <= gnt_wait - 2'd1;
      if (mem_rvalid_o)
        pend <= 1'b0;
      else if (pend)
        rv_wait <= rv_wait - 2'd1;
    end
  end

endmodule

// ==== testbench/lsu_tb.sv ====
module lsu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int                  CLK_PERIOD = 100;
  localparam logic [LSU_XLEN-1:0] STORE_WORD = 32'h4433_2211;  // distinct bytes per lane

  typedef struct packed
  {
    lsu_req_t req;
    logic     err_inj;   // bus error at grant
    mem_cmd_t cmd;       // expected memory command
    logic     mis;       // expected misaligned flag
    lsu_rsp_t rsp;       // expected response
  } entry_t;

  logic                clk = 1'b0;
  logic                rst_n;
  lsu_req_t            req;
  logic                req_valid;
  logic                req_ready;
  logic                misaligned;
  logic                mem_req;
  mem_cmd_t            mem_cmd;
  logic                mem_gnt;
  logic                mem_rvalid;
  logic                mem_err;
  logic [LSU_XLEN-1:0] mem_rdata;
  lsu_rsp_t            rsp;
  logic                rsp_valid;
  logic                rsp_ready = 1'b0;
  logic                busy;
  logic                err_inj;

  entry_t   tests[$];
  lsu_rsp_t expect_q[$];   // responses owed, in grant order
  int       num_tests = 0;
  int       rsp_count = 0;
  int       cmd_errs  = 0;
  int       rsp_errs  = 0;
  int       flow_errs = 0;
  int       in_flight = 0;   // accesses accepted and not yet answered
  logic     rsp_waiting = 1'b0;
  integer   seed = 32'h19ca2848;

  always #(CLK_PERIOD/2) clk = ~clk;

  lsu_top dut0
  (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .req_i        ( req        ),
    .req_valid_i  ( req_valid  ),
    .req_ready_o  ( req_ready  ),
    .misaligned_o ( misaligned ),
    .mem_req_o    ( mem_req    ),
    .mem_cmd_o    ( mem_cmd    ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_err_i    ( mem_err    ),
    .mem_rdata_i  ( mem_rdata  ),
    .rsp_o        ( rsp        ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_ready_i  ( rsp_ready  ),
    .busy_o       ( busy       )
  );

  lsu_mem_model u_mem
  (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .mem_req_i    ( mem_req    ),
    .mem_cmd_i    ( mem_cmd    ),
    .err_inject_i ( err_inj    ),
    .mem_gnt_o    ( mem_gnt    ),
    .mem_rvalid_o ( mem_rvalid ),
    .mem_err_o    ( mem_err    ),
    .mem_rdata_o  ( mem_rdata  )
  );

  ////////////////////
  // table builders
  ////////////////////

  task automatic load_entry
  (
    input lsu_size_e           size,
    input logic                sign_ext,
    input logic [LSU_XLEN-1:0] op_a,
    input logic [LSU_XLEN-1:0] op_b,
    input logic                use_incr,
    input logic                err,
    input logic [LSU_XLEN-1:0] exp_addr,
    input logic [3:0]          exp_be,
    input logic                exp_mis,
    input logic [LSU_XLEN-1:0] exp_rdata
  );
    entry_t e;
    e = '0;                 // load carries no store data
    e.req.size     = size;
    e.req.sign_ext = sign_ext;
    e.req.op_a     = op_a;
    e.req.op_b     = op_b;
    e.req.use_incr = use_incr;
    e.err_inj      = err;
    e.cmd.addr     = exp_addr;
    e.cmd.be       = exp_be;
    e.mis          = exp_mis;
    e.rsp.rdata    = exp_rdata;
    e.rsp.err      = err;
    tests.push_back(e);
  endtask

  task automatic store_entry
  (
    input lsu_size_e           size,
    input logic [LSU_XLEN-1:0] op_a,
    input logic [LSU_XLEN-1:0] op_b,
    input logic                use_incr,
    input logic [1:0]          reg_off,
    input logic                err,
    input logic [LSU_XLEN-1:0] exp_addr,
    input logic [3:0]          exp_be,
    input logic [LSU_XLEN-1:0] exp_wdata,
    input logic                exp_mis
  );
    entry_t e;
    e = '0;
    e.req.we         = 1'b1;
    e.req.size       = size;
    e.req.op_a       = op_a;
    e.req.op_b       = op_b;
    e.req.use_incr   = use_incr;
    e.req.wdata      = STORE_WORD;
    e.req.reg_offset = reg_off;
    e.err_inj        = err;
    e.cmd.addr       = exp_addr;
    e.cmd.we         = 1'b1;
    e.cmd.be         = exp_be;
    e.cmd.wdata      = exp_wdata;
    e.mis            = exp_mis;
    e.rsp.err        = err;    // memory answers stores with zero
    e.rsp.we         = 1'b1;
    tests.push_back(e);
  endtask

  // preset words: 0 fc02fe00, 1 f806fa04, 2 f40af608, 3 f00ef20c, 9 d826da24
  task automatic build_table();
    load_entry(SIZE_WORD, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 4'b1111, 1'b0, 32'hfc02_fe00);
    load_entry(SIZE_WORD, 1'b1, 32'h2, 32'h2, 1'b1, 1'b0, 32'h4, 4'b1111, 1'b0, 32'hf806_fa04);
    load_entry(SIZE_WORD, 1'b0, 32'h4, 32'h1, 1'b1, 1'b0, 32'h5, 4'b1110, 1'b1, 32'h00f8_06fa);
    load_entry(SIZE_WORD, 1'b0, 32'h6, 32'h0, 1'b0, 1'b0, 32'h6, 4'b1100, 1'b1, 32'h0000_f806);
    load_entry(SIZE_WORD, 1'b0, 32'h7, 32'h100, 1'b0, 1'b1, 32'h7, 4'b1000, 1'b1, 32'h0000_00f8);
    load_entry(SIZE_HALF, 1'b0, 32'h8, 32'h0, 1'b0, 1'b0, 32'h8, 4'b0011, 1'b0, 32'h0000_f608);
    load_entry(SIZE_HALF, 1'b1, 32'h8, 32'h0, 1'b0, 1'b0, 32'h8, 4'b0011, 1'b0, 32'hffff_f608);
    load_entry(SIZE_HALF, 1'b1, 32'h4, 32'h5, 1'b1, 1'b0, 32'h9, 4'b0110, 1'b0, 32'h0000_0af6);
    load_entry(SIZE_HALF, 1'b1, 32'ha, 32'h0, 1'b0, 1'b0, 32'ha, 4'b1100, 1'b0, 32'hffff_f40a);
    load_entry(SIZE_HALF, 1'b1, 32'hb, 32'h0, 1'b0, 1'b0, 32'hb, 4'b1000, 1'b1, 32'h0000_00f4);
    load_entry(SIZE_BYTE, 1'b0, 32'hc, 32'h0, 1'b0, 1'b0, 32'hc, 4'b0001, 1'b0, 32'h0000_000c);
    load_entry(SIZE_BYTE, 1'b1, 32'hd, 32'h0, 1'b0, 1'b1, 32'hd, 4'b0010, 1'b0, 32'hffff_fff2);
    load_entry(SIZE_BYTE, 1'b0, 32'hd, 32'h0, 1'b0, 1'b0, 32'hd, 4'b0010, 1'b0, 32'h0000_00f2);
    load_entry(SIZE_BYTE, 1'b1, 32'he, 32'h0, 1'b0, 1'b0, 32'he, 4'b0100, 1'b0, 32'h0000_000e);
    load_entry(SIZE_BYTE, 1'b1, 32'hf, 32'h0, 1'b0, 1'b0, 32'hf, 4'b1000, 1'b0, 32'hffff_fff0);
    load_entry(SIZE_BYTE, 1'b0, 32'h1, 32'h30, 1'b0, 1'b0, 32'h1, 4'b0010, 1'b0, 32'h0000_00fe);
    // stores go to words 8..15 with data rotated by address offset minus register offset
    store_entry(SIZE_WORD, 32'h20, 32'h0, 1'b0, 2'd0, 1'b0, 32'h20, 4'b1111, 32'h4433_2211, 1'b0);
    store_entry(SIZE_HALF, 32'h24, 32'h0, 1'b0, 2'd2, 1'b0, 32'h24, 4'b0011, 32'h2211_4433, 1'b0);
    store_entry(SIZE_HALF, 32'h20, 32'h9, 1'b1, 2'd0, 1'b0, 32'h29, 4'b0110, 32'h3322_1144, 1'b0);
    store_entry(SIZE_HALF, 32'h2a, 32'h0, 1'b0, 2'd1, 1'b0, 32'h2a, 4'b1100, 32'h3322_1144, 1'b0);
    store_entry(SIZE_BYTE, 32'h2c, 32'h0, 1'b0, 2'd3, 1'b0, 32'h2c, 4'b0001, 32'h3322_1144, 1'b0);
    store_entry(SIZE_BYTE, 32'h2d, 32'h0, 1'b0, 2'd2, 1'b0, 32'h2d, 4'b0010, 32'h1144_3322, 1'b0);
    store_entry(SIZE_BYTE, 32'h2e, 32'h0, 1'b0, 2'd0, 1'b0, 32'h2e, 4'b0100, 32'h2211_4433, 1'b0);
    store_entry(SIZE_BYTE, 32'h2f, 32'h0, 1'b0, 2'd1, 1'b0, 32'h2f, 4'b1000, 32'h2211_4433, 1'b0);
    store_entry(SIZE_WORD, 32'h31, 32'h0, 1'b0, 2'd0, 1'b0, 32'h31, 4'b1110, 32'h3322_1144, 1'b1);
    store_entry(SIZE_HALF, 32'h37, 32'h0, 1'b0, 2'd3, 1'b0, 32'h37, 4'b1000, 32'h4433_2211, 1'b1);
    store_entry(SIZE_WORD, 32'h30, 32'h8, 1'b1, 2'd0, 1'b1, 32'h38, 4'b1111, 32'h4433_2211, 1'b0);
    // read back what the stores left behind
    load_entry(SIZE_WORD, 1'b0, 32'h20, 32'h0, 1'b0, 1'b0, 32'h20, 4'b1111, 1'b0, 32'h4433_2211);
    load_entry(SIZE_HALF, 1'b0, 32'h24, 32'h0, 1'b0, 1'b0, 32'h24, 4'b0011, 1'b0, 32'h0000_4433);
    load_entry(SIZE_BYTE, 1'b1, 32'h2e, 32'h0, 1'b0, 1'b0, 32'h2e, 4'b0100, 1'b0, 32'h0000_0011);
    load_entry(SIZE_BYTE, 1'b0, 32'h2d, 32'h0, 1'b0, 1'b0, 32'h2d, 4'b0010, 1'b0, 32'h0000_0033);
  endtask

  ////////////////////
  // driver
  ////////////////////

  // write-back stalls about one cycle in four
  always @(posedge clk)
  begin
    logic [31:0] rnd;
    rnd = $random(seed);
    rsp_ready <= (rnd[1:0] != 2'b00);
  end

  initial
  begin
    logic accepted;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    err_inj   = 1'b0;
    build_table();
    num_tests = tests.size();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int idx = 0; idx < num_tests; idx++)
    begin
      req       <= tests[idx].req;
      req_valid <= 1'b1;
      err_inj   <= tests[idx].err_inj;
      accepted   = 1'b0;
      while (!accepted)
      begin
        @(negedge clk);                      // inputs settled and handshake decided
        if (req_ready)
        begin
          accepted = 1'b1;
          assert ((mem_cmd == tests[idx].cmd) && (misaligned == tests[idx].mis))
          else
          begin
            $display("error %0t ns: entry %0d cmd %h %b %b %h mis %b, expected %h %b %b %h mis %b",
                     $time, idx, mem_cmd.addr, mem_cmd.we, mem_cmd.be, mem_cmd.wdata,
                     misaligned, tests[idx].cmd.addr, tests[idx].cmd.we, tests[idx].cmd.be,
                     tests[idx].cmd.wdata, tests[idx].mis);
            cmd_errs++;
          end
          expect_q.push_back(tests[idx].rsp);
        end
        @(posedge clk);
      end
    end
    req_valid <= 1'b0;
    err_inj   <= 1'b0;
    wait (rsp_count == num_tests);
    @(posedge clk);                          // last response taken here
    @(negedge clk);
    assert (!busy)
    else
    begin
      $display("busy is still high after the last response at %0t ns", $time);
      flow_errs++;
    end
    $display("errors: command %0d, response %0d, flow %0d", cmd_errs, rsp_errs, flow_errs);
    if (cmd_errs + rsp_errs + flow_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  ////////////////////
  // response monitor
  ////////////////////

  always @(negedge clk)
  begin
    lsu_rsp_t exp_rsp;
    logic     may_issue;
    if (!rst_n)
    begin
      // all handshake outputs quiet in reset
      assert (!mem_req && !req_ready && !rsp_valid && !busy)
      else
      begin
        $display("handshake outputs are not low during reset at %0t ns", $time);
        flow_errs++;
      end
    end
    else
    begin
      // nothing outstanding, or the answer leaves in this very cycle
      may_issue = (in_flight == 0) || (mem_rvalid && rsp_ready);
      assert ((mem_req == (req_valid && may_issue)) && (req_ready == (may_issue && mem_gnt)))
      else
      begin
        $display("error %0t ns: mem_req %b req_ready %b, expected %b %b",
                 $time, mem_req, req_ready, req_valid && may_issue, may_issue && mem_gnt);
        flow_errs++;
      end
      // a stalled response blocks new requests
      assert (!((rsp_waiting || (rsp_valid && !rsp_ready)) && req_ready))
      else
      begin
        $display("request accepted while a response was waiting at %0t ns", $time);
        flow_errs++;
      end
      if (rsp_valid && rsp_ready)
      begin
        assert (expect_q.size() != 0)
        else
        begin
          $display("response delivered with no access outstanding at %0t ns", $time);
          flow_errs++;
        end
        if (expect_q.size() != 0)
        begin
          exp_rsp = expect_q.pop_front();
          assert (rsp == exp_rsp)
          else
          begin
            $display("error %0t ns: response %0d rdata %h err %b we %b, expected %h %b %b",
                     $time, rsp_count, rsp.rdata, rsp.err, rsp.we,
                     exp_rsp.rdata, exp_rsp.err, exp_rsp.we);
            rsp_errs++;
          end
          rsp_count++;
        end
      end
      if (req_valid && req_ready)
        in_flight++;
      if (rsp_valid && rsp_ready)
        in_flight--;
      rsp_waiting = rsp_valid && !rsp_ready;
    end
  end

  // watchdog allows 20 cycles per table entry
  initial
  begin
    wait (num_tests > 0);
    #(num_tests * 20 * CLK_PERIOD);
    $display("simulation timed out after %0d cycles, %0d of %0d responses seen",
             num_tests * 20, rsp_count, num_tests);
    $display(">>> FAIL");
    $finish;
  end

endmodule
